// File: logic/corePkg.sv
// Core package with widths, opcodes, reset PC and the pipeline stage payloads
`default_nettype none

package corePkg;

	localparam int dataWidth = 32;
	localparam int instrWidth = 16;
	localparam int regCount = 16;
	localparam int regIdWidth = 4;

	localparam logic [regIdWidth-1:0] zeroReg = 4'd0;    // Reads zero, writes dropped
	localparam logic [dataWidth-1:0] resetPc = 32'd0;
	localparam logic [dataWidth-1:0] pcStep = 32'd2;     // One 16-bit word per step

	// Opcode field is instr[15:12]; unlisted codes decode as NOP
	typedef enum logic [3:0]
	{
		NOP  = 4'd0,
		ADD  = 4'd1,
		SUB  = 4'd2,
		AND  = 4'd3,
		OR   = 4'd4,
		XOR  = 4'd5,
		MOVI = 4'd6,
		ADDI = 4'd7,
		BRA  = 4'd8,
		BZ   = 4'd9
	} opcode_t;

	// Fetch to decode
	typedef struct packed
	{
		logic [dataWidth-1:0] pc;
		logic [instrWidth-1:0] instr;
	} fetchWord_t;

	// Decode to register read
	typedef struct packed
	{
		logic [dataWidth-1:0] pc;
		opcode_t op;
		logic [regIdWidth-1:0] destReg;
		logic writesDest;
		logic [regIdWidth-1:0] srcA;    // zeroReg when unused
		logic [regIdWidth-1:0] srcB;
		logic [dataWidth-1:0] imm;      // Already sign-extended
		logic isBranch;
	} decodedOp_t;

	// Register read to EX1, sources now carry values
	typedef struct packed
	{
		logic [dataWidth-1:0] pc;
		opcode_t op;
		logic [regIdWidth-1:0] destReg;
		logic writesDest;
		logic [dataWidth-1:0] valA;
		logic [dataWidth-1:0] valB;
		logic [dataWidth-1:0] imm;
		logic isBranch;
	} execOp_t;

	// EX1 to EX2 and write-back
	typedef struct packed
	{
		logic [regIdWidth-1:0] destReg;
		logic writesDest;
		logic [dataWidth-1:0] result;
	} wbOp_t;

endpackage

`default_nettype wire

// File: logic/pipeStage.sv
// Pipeline stage register carrying one payload and its valid flag, with hold and kill
`default_nettype none

module pipeStage #(
	parameter type payload_t = logic
) (
	input  logic     clock,
	input  logic     reset,
	input  logic     hold,      // Keep current contents
	input  logic     kill,      // Load a bubble
	input  payload_t dIn,
	input  logic     dValid,
	output payload_t q,
	output logic     qValid
);

	// Hold wins over kill
	always_ff @(posedge clock)
	begin
		if (reset)
			qValid <= 1'b0;
		else if (!hold)
			qValid <= dValid && !kill;
	end

	always_ff @(posedge clock)
	begin
		if (!hold)
			q <= dIn;    // Payload is don't-care while invalid
	end

endmodule

`default_nettype wire

// File: logic/fetchUnit.sv
// Fetch unit holding the PC, stepping or redirecting it and pairing it with the fetched word
`default_nettype none

module fetchUnit (
	input  logic                            clock,
	input  logic                            reset,
	input  logic                            hold,
	input  logic                            redirect,
	input  logic [corePkg::dataWidth-1:0]   target,
	output logic [corePkg::dataWidth-1:0]   instrAddr,
	input  logic [corePkg::instrWidth-1:0]  instrData,
	output corePkg::fetchWord_t             fetched
);

	logic [corePkg::dataWidth-1:0] pc;

	always_ff @(posedge clock)
	begin
		if (reset)
			pc <= corePkg::resetPc;
		else if (hold)
			pc <= pc;    // Stalled, same address again next cycle
		else if (redirect)
			pc <= target;
		else
			pc <= pc + corePkg::pcStep;
	end

	assign instrAddr = pc;

	// Port answers in the same cycle
	assign fetched.pc = pc;
	assign fetched.instr = instrData;

endmodule

`default_nettype wire

// File: logic/instrDecoder.sv
// Instruction decoder producing operation, register numbers, immediate and branch flag
`default_nettype none

module instrDecoder (
	input  corePkg::fetchWord_t word,
	output corePkg::decodedOp_t decoded
);

	logic [3:0] rawOp;
	logic [corePkg::regIdWidth-1:0] rn;
	logic [corePkg::regIdWidth-1:0] rm;
	logic [corePkg::regIdWidth-1:0] ro;
	logic [corePkg::dataWidth-1:0] imm8;
	logic [corePkg::dataWidth-1:0] imm12;

	assign rawOp = word.instr[15:12];
	assign rn = word.instr[11:8];
	assign rm = word.instr[7:4];
	assign ro = word.instr[3:0];
	assign imm8 = {{(corePkg::dataWidth-8){word.instr[7]}}, word.instr[7:0]};
	assign imm12 = {{(corePkg::dataWidth-12){word.instr[11]}}, word.instr[11:0]};

	always_comb
	begin
		decoded.pc = word.pc;
		decoded.op = corePkg::NOP;
		decoded.destReg = corePkg::zeroReg;
		decoded.writesDest = 1'b0;
		decoded.srcA = corePkg::zeroReg;    // Unused sources never interlock
		decoded.srcB = corePkg::zeroReg;
		decoded.imm = imm8;
		decoded.isBranch = 1'b0;

		case (rawOp)
			4'd1, 4'd2, 4'd3, 4'd4, 4'd5:
			begin
				// rn = rm op ro
				decoded.op = corePkg::opcode_t'(rawOp);
				decoded.destReg = rn;
				decoded.writesDest = 1'b1;
				decoded.srcA = rm;
				decoded.srcB = ro;
			end
			4'd6:
			begin
				decoded.op = corePkg::MOVI;
				decoded.destReg = rn;
				decoded.writesDest = 1'b1;
			end
			4'd7:
			begin
				decoded.op = corePkg::ADDI;
				decoded.destReg = rn;
				decoded.writesDest = 1'b1;
				decoded.srcA = rn;    // Reads its own destination
			end
			4'd8:
			begin
				decoded.op = corePkg::BRA;
				decoded.imm = imm12;
				decoded.isBranch = 1'b1;
			end
			4'd9:
			begin
				decoded.op = corePkg::BZ;
				decoded.srcA = rn;    // Tested against zero
				decoded.isBranch = 1'b1;
			end
			default:
			begin
				decoded.op = corePkg::NOP;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: logic/regFile.sv
// Register file with sixteen registers, two read ports, one write port and write-through
`default_nettype none

module regFile (
	input  logic                             clock,
	input  logic                             reset,
	input  logic [corePkg::regIdWidth-1:0]   readA,
	input  logic [corePkg::regIdWidth-1:0]   readB,
	output logic [corePkg::dataWidth-1:0]    valueA,
	output logic [corePkg::dataWidth-1:0]    valueB,
	input  corePkg::wbOp_t                   write,
	input  logic                             writeEnable
);

	logic [corePkg::dataWidth-1:0] regs [corePkg::regCount];

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < corePkg::regCount; i++)
				regs[i] <= '0;
		end
		else if (writeEnable && write.destReg != corePkg::zeroReg)
			regs[write.destReg] <= write.result;
	end

	// Same-cycle write is seen by the reader, so EX2 needs no interlock
	always_comb
	begin
		if (readA == corePkg::zeroReg)
			valueA = '0;
		else if (writeEnable && write.destReg == readA)
			valueA = write.result;
		else
			valueA = regs[readA];

		if (readB == corePkg::zeroReg)
			valueB = '0;
		else if (writeEnable && write.destReg == readB)
			valueB = write.result;
		else
			valueB = regs[readB];
	end

endmodule

`default_nettype wire

// File: logic/pipeControl.sv
// Pipeline control for fetch stalls, the register interlock and branch squash
`default_nettype none

module pipeControl (
	input  logic                 fetchReady,
	input  corePkg::decodedOp_t  readOp,
	input  logic                 readValid,
	input  corePkg::execOp_t     execOp,
	input  logic                 execValid,
	input  logic                 branchTaken,
	output logic                 holdAll,
	output logic                 holdFront,
	output logic                 bubble,
	output logic                 squash
);

	logic destPending;
	logic interlock;

	// EX1 result not yet in the register file
	assign destPending = execValid && execOp.writesDest &&
		(execOp.destReg != corePkg::zeroReg);

	assign interlock = readValid && destPending &&
		((readOp.srcA == execOp.destReg) || (readOp.srcB == execOp.destReg));

	assign holdAll = !fetchReady;    // Freezes every stage and the PC
	assign squash = execValid && branchTaken;

	// Branch in EX1 beats the interlock, fetch stall beats both
	assign holdFront = holdAll || (interlock && !squash);
	assign bubble = squash || interlock;

endmodule

`default_nettype wire

// File: logic/execUnit.sv
// Execute unit computing the ALU result, branch decision and branch target
`default_nettype none

module execUnit (
	input  corePkg::execOp_t               op,
	output corePkg::wbOp_t                 result,
	output logic                           branchTaken,
	output logic [corePkg::dataWidth-1:0]  branchTarget
);

	logic [corePkg::dataWidth-1:0] aluOut;

	always_comb
	begin
		case (op.op)
			corePkg::ADD:  aluOut = op.valA + op.valB;
			corePkg::SUB:  aluOut = op.valA - op.valB;
			corePkg::AND:  aluOut = op.valA & op.valB;
			corePkg::OR:   aluOut = op.valA | op.valB;
			corePkg::XOR:  aluOut = op.valA ^ op.valB;
			corePkg::MOVI: aluOut = op.imm;
			corePkg::ADDI: aluOut = op.valA + op.imm;
			default:       aluOut = '0;
		endcase
	end

	// BZ tests rn, which decode placed in srcA
	always_comb
	begin
		branchTaken = 1'b0;
		if (op.isBranch)
		begin
			if (op.op == corePkg::BRA)
				branchTaken = 1'b1;
			else if (op.op == corePkg::BZ)
				branchTaken = (op.valA == '0);
		end
	end

	// Offset counts 16-bit words from the next instruction
	assign branchTarget = op.pc + corePkg::pcStep + {op.imm[corePkg::dataWidth-2:0], 1'b0};

	assign result.destReg = op.destReg;
	assign result.writesDest = op.writesDest;
	assign result.result = aluOut;

endmodule

`default_nettype wire

// File: logic/coreTop.sv
// Five-stage core top level connecting fetch, decode, register read, execute and write-back
`default_nettype none

module coreTop (
	input  logic                             clock,
	input  logic                             reset,
	output logic [corePkg::dataWidth-1:0]    instrAddr,
	input  logic [corePkg::instrWidth-1:0]   instrData,
	input  logic                             instrReady,
	output logic                             wbValid,
	output logic [corePkg::regIdWidth-1:0]   wbReg,
	output logic [corePkg::dataWidth-1:0]    wbValue
);

	corePkg::fetchWord_t fetched;
	corePkg::fetchWord_t fetchQ;
	logic fetchValid;
	corePkg::decodedOp_t decoded;
	corePkg::decodedOp_t readQ;
	logic readValid;
	logic [corePkg::dataWidth-1:0] valA;
	logic [corePkg::dataWidth-1:0] valB;
	corePkg::execOp_t execIn;
	corePkg::execOp_t execQ;
	logic execValid;
	corePkg::wbOp_t execResult;
	corePkg::wbOp_t wbQ;
	logic wbQValid;
	logic branchTaken;
	logic [corePkg::dataWidth-1:0] branchTarget;
	logic holdAll;
	logic holdFront;
	logic bubble;
	logic squash;
	logic commit;

	fetchUnit fetchUnit_inst (
		.clock(clock), .reset(reset),
		.hold(holdFront), .redirect(squash), .target(branchTarget),
		.instrAddr(instrAddr), .instrData(instrData), .fetched(fetched)
	);

	// Stage A, fetch to decode
	pipeStage #(.payload_t(corePkg::fetchWord_t)) stageA_inst (
		.clock(clock), .reset(reset), .hold(holdFront), .kill(squash),
		.dIn(fetched), .dValid(1'b1), .q(fetchQ), .qValid(fetchValid)
	);

	instrDecoder instrDecoder_inst (.word(fetchQ), .decoded(decoded));

	// Stage B, decode to register read
	pipeStage #(.payload_t(corePkg::decodedOp_t)) stageB_inst (
		.clock(clock), .reset(reset), .hold(holdFront), .kill(squash),
		.dIn(decoded), .dValid(fetchValid), .q(readQ), .qValid(readValid)
	);

	regFile regFile_inst (
		.clock(clock), .reset(reset),
		.readA(readQ.srcA), .readB(readQ.srcB), .valueA(valA), .valueB(valB),
		.write(wbQ), .writeEnable(commit)
	);

	assign execIn = '{pc: readQ.pc, op: readQ.op, destReg: readQ.destReg,
		writesDest: readQ.writesDest, valA: valA, valB: valB, imm: readQ.imm,
		isBranch: readQ.isBranch};

	// Stage C, register read to EX1
	pipeStage #(.payload_t(corePkg::execOp_t)) stageC_inst (
		.clock(clock), .reset(reset), .hold(holdAll), .kill(bubble),
		.dIn(execIn), .dValid(readValid), .q(execQ), .qValid(execValid)
	);

	execUnit execUnit_inst (
		.op(execQ), .result(execResult),
		.branchTaken(branchTaken), .branchTarget(branchTarget)
	);

	// Stage D, EX1 to write-back
	pipeStage #(.payload_t(corePkg::wbOp_t)) stageD_inst (
		.clock(clock), .reset(reset), .hold(holdAll), .kill(1'b0),
		.dIn(execResult), .dValid(execValid), .q(wbQ), .qValid(wbQValid)
	);

	pipeControl pipeControl_inst (
		.fetchReady(instrReady),
		.readOp(readQ), .readValid(readValid),
		.execOp(execQ), .execValid(execValid), .branchTaken(branchTaken),
		.holdAll(holdAll), .holdFront(holdFront), .bubble(bubble), .squash(squash)
	);

	// Write lands only on the edge where stage D moves on
	assign commit = wbQValid && !holdAll && wbQ.writesDest &&
		(wbQ.destReg != corePkg::zeroReg);

	assign wbValid = commit;
	assign wbReg = wbQ.destReg;
	assign wbValue = wbQ.result;

endmodule

`default_nettype wire

// File: bench/coreTb.sv
// Directed testbench for the five-stage core with program memory and an ISA reference model
`default_nettype none

module coreTb;

	logic clock;
	logic reset;
	logic instrReady;
	logic [corePkg::dataWidth-1:0] instrAddr;
	logic [corePkg::instrWidth-1:0] instrData;
	logic wbValid;
	logic [corePkg::regIdWidth-1:0] wbReg;
	logic [corePkg::dataWidth-1:0] wbValue;

	logic [corePkg::instrWidth-1:0] progMem [256];
	logic [corePkg::instrWidth-1:0] progQ [$];    // Program being built by a test
	corePkg::wbOp_t expected [$];
	corePkg::wbOp_t observed;
	logic stallMode;
	int cycleCount;
	int cycleLimit;

	coreTop coreTop_inst (
		.clock(clock), .reset(reset),
		.instrAddr(instrAddr), .instrData(instrData), .instrReady(instrReady),
		.wbValid(wbValid), .wbReg(wbReg), .wbValue(wbValue)
	);

	assign instrData = progMem[instrAddr[8:1]];    // Same-cycle answer
	assign observed = '{destReg: wbReg, writesDest: wbValid, result: wbValue};

	always #20 clock = ~clock;

	always @(posedge clock)
		instrReady <= stallMode ? ($urandom % 4 != 0) : 1'b1;

	task automatic stopOnError;
		$display("Finished with errors");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	always @(posedge clock)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount > cycleLimit)
		begin
			$display("Timeout after %0d cycles, the core stopped making progress", cycleCount);
			stopOnError();
		end
	end

	task automatic checkWrite(input corePkg::wbOp_t want, input corePkg::wbOp_t got);
		if (got !== want)
		begin
			$display("[FAIL] %0t: write-back expected r%0d = %h, got r%0d = %h",
				$time, want.destReg, want.result, got.destReg, got.result);
			stopOnError();
		end
	endtask

	task automatic checkFetch(input logic [corePkg::dataWidth-1:0] want,
		input logic [corePkg::dataWidth-1:0] got);
		if (got !== want)
		begin
			$display("[FAIL] %0t: instrAddr expected %h, got %h", $time, want, got);
			stopOnError();
		end
	endtask

	// Each committed write is matched in order against the model
	always @(negedge clock)
	begin
		if (!reset && wbValid)
		begin
			if (expected.size() == 0)
			begin
				$display("[FAIL] %0t: unexpected write-back r%0d = %h", $time, wbReg, wbValue);
				stopOnError();
			end
			else
				checkWrite(expected.pop_front(), observed);
		end
	end

	function automatic logic [15:0] encodeAlu(input corePkg::opcode_t op,
		input logic [3:0] rn, input logic [3:0] rm, input logic [3:0] ro);
		return {op, rn, rm, ro};
	endfunction

	function automatic logic [15:0] encodeImm(input corePkg::opcode_t op,
		input logic [3:0] rn, input logic [7:0] imm);
		return {op, rn, imm};
	endfunction

	function automatic logic [15:0] encodeBra(input logic [11:0] offset);
		return {corePkg::BRA, offset};
	endfunction

	task automatic emit(input logic [15:0] word);
		progQ.push_back(word);
	endtask

	// Marker write to r15, then a branch onto itself
	task automatic emitEnd;
		emit(encodeImm(corePkg::MOVI, 4'd15, 8'h5A));
		emit(encodeBra(12'hFFF));
	endtask

	// ISA model running from address 0 up to the self-branch
	task automatic modelProgram(output int steps);
		logic [31:0] regs [16];
		logic [31:0] pc;
		logic [31:0] imm;
		logic [31:0] value;
		logic [15:0] instr;
		logic [3:0] rn;
		logic [3:0] rm;
		logic [3:0] ro;
		logic writes;
		regs = '{default: '0};
		pc = 32'd0;
		steps = 0;
		expected.delete();
		while (steps < 200)
		begin
			instr = progMem[pc[8:1]];
			if (instr == encodeBra(12'hFFF))
				break;
			rn = instr[11:8];
			rm = instr[7:4];
			ro = instr[3:0];
			imm = {{24{instr[7]}}, instr[7:0]};
			writes = 1'b1;
			value = '0;
			case (corePkg::opcode_t'(instr[15:12]))
				corePkg::ADD:  value = regs[rm] + regs[ro];
				corePkg::SUB:  value = regs[rm] - regs[ro];
				corePkg::AND:  value = regs[rm] & regs[ro];
				corePkg::OR:   value = regs[rm] | regs[ro];
				corePkg::XOR:  value = regs[rm] ^ regs[ro];
				corePkg::MOVI: value = imm;
				corePkg::ADDI: value = regs[rn] + imm;
				corePkg::BRA:
				begin
					writes = 1'b0;
					pc = pc + {{19{instr[11]}}, instr[11:0], 1'b0};
				end
				corePkg::BZ:
				begin
					writes = 1'b0;
					if (regs[rn] == 32'd0)
						pc = pc + {imm[30:0], 1'b0};
				end
				default: writes = 1'b0;
			endcase
			pc = pc + 32'd2;
			if (writes && rn != 4'd0)    // r0 never changes
			begin
				regs[rn] = value;
				expected.push_back(corePkg::wbOp_t'{destReg: rn, writesDest: 1'b1,
					result: value});
			end
			steps++;
		end
	endtask

	task automatic startProgram;
		int steps;
		@(posedge clock);
		reset <= 1'b1;
		@(negedge clock);
		progMem = '{default: '0};
		for (int i = 0; i < progQ.size(); i++)
			progMem[i] = progQ[i];
		modelProgram(steps);
		cycleLimit = cycleLimit + 20 * steps + 10;    // Reset and idle cycles on top
		repeat (3) @(posedge clock);
		reset <= 1'b0;
	endtask

	// Idle cycles afterwards catch writes past the marker
	task automatic finishProgram;
		while (expected.size() != 0)
			@(negedge clock);
		repeat (4) @(negedge clock);
	endtask

	task automatic emitAluMix;
		emit(encodeImm(corePkg::MOVI, 4'd1, 8'h35));
		emit(encodeImm(corePkg::MOVI, 4'd2, 8'hFD));
		emit(encodeImm(corePkg::MOVI, 4'd3, 8'h0F));
		emit(encodeImm(corePkg::MOVI, 4'd4, 8'h70));
		emit(encodeAlu(corePkg::ADD, 4'd5, 4'd1, 4'd2));
		emit(encodeAlu(corePkg::SUB, 4'd6, 4'd3, 4'd4));
		emit(encodeAlu(corePkg::AND, 4'd7, 4'd1, 4'd3));
		emit(encodeAlu(corePkg::OR, 4'd8, 4'd2, 4'd4));
		emit(encodeAlu(corePkg::XOR, 4'd9, 4'd1, 4'd4));
	endtask

	task automatic emitDependentChain;
		emit(encodeImm(corePkg::MOVI, 4'd1, 8'h05));
		emit(encodeImm(corePkg::ADDI, 4'd1, 8'h03));
		emit(encodeImm(corePkg::ADDI, 4'd1, 8'hFF));
		emit(encodeAlu(corePkg::ADD, 4'd2, 4'd1, 4'd1));
		emit(encodeAlu(corePkg::SUB, 4'd3, 4'd2, 4'd1));
		emit(encodeAlu(corePkg::XOR, 4'd4, 4'd3, 4'd2));
		emit(encodeImm(corePkg::ADDI, 4'd4, 8'h10));
	endtask

	task automatic testAluIndependent;
		progQ.delete();
		emitAluMix();
		emitEnd();
		startProgram();
		finishProgram();
	endtask

	task automatic testDependentChain;
		progQ.delete();
		emitDependentChain();
		emitEnd();
		startProgram();
		finishProgram();
	endtask

	task automatic testRandomStalls;
		progQ.delete();
		emitDependentChain();
		emitAluMix();
		emitEnd();
		stallMode = 1'b1;
		startProgram();
		finishProgram();
		stallMode = 1'b0;
	endtask

	// BRA at address 4 jumps over four writes to address 14
	task automatic testBranchSkip;
		progQ.delete();
		emit(encodeImm(corePkg::MOVI, 4'd1, 8'h01));
		emit(encodeImm(corePkg::MOVI, 4'd2, 8'h02));
		emit(encodeBra(12'h004));
		emit(encodeImm(corePkg::MOVI, 4'd3, 8'h33));
		emit(encodeImm(corePkg::MOVI, 4'd4, 8'h44));
		emit(encodeImm(corePkg::MOVI, 4'd5, 8'h55));
		emit(encodeImm(corePkg::MOVI, 4'd6, 8'h66));
		emit(encodeImm(corePkg::MOVI, 4'd7, 8'h77));
		emitEnd();
		startProgram();
		@(negedge clock);
		while (instrAddr != 32'd4)
			@(negedge clock);
		while (instrAddr == 32'd4)    // Leaves once the BRA enters stage A
			@(negedge clock);
		repeat (3) @(posedge clock);
		@(negedge clock);
		checkFetch(32'd14, instrAddr);    // Sequential fetch would sit at 12
		finishProgram();
	endtask

	task automatic testBranchLoop;
		progQ.delete();
		emit(encodeImm(corePkg::MOVI, 4'd1, 8'h03));
		emit(encodeImm(corePkg::MOVI, 4'd2, 8'h00));
		emit(encodeImm(corePkg::ADDI, 4'd2, 8'h01));    // Loop head at 4
		emit(encodeImm(corePkg::ADDI, 4'd1, 8'hFF));
		emit(encodeImm(corePkg::BZ, 4'd1, 8'h01));      // Exit to 12 at zero
		emit(encodeBra(12'hFFC));
		emit(encodeImm(corePkg::MOVI, 4'd3, 8'h77));
		emitEnd();
		startProgram();
		finishProgram();
	endtask

	task automatic testZeroRegister;
		progQ.delete();
		emit(encodeImm(corePkg::MOVI, 4'd0, 8'h12));
		emit(encodeImm(corePkg::MOVI, 4'd1, 8'h05));
		emit(encodeAlu(corePkg::ADD, 4'd0, 4'd1, 4'd1));
		emit(encodeAlu(corePkg::ADD, 4'd2, 4'd0, 4'd1));
		emit(encodeImm(corePkg::ADDI, 4'd0, 8'h07));
		emit(encodeAlu(corePkg::OR, 4'd3, 4'd0, 4'd0));
		emitEnd();
		startProgram();
		finishProgram();
	endtask

	initial
	begin
		clock = 1'b0;
		reset = 1'b1;
		instrReady = 1'b1;
		stallMode = 1'b0;
		cycleCount = 0;
		cycleLimit = 10;
		progMem = '{default: '0};
		void'($urandom(32'hfc68));

		testAluIndependent();
		testDependentChain();
		testRandomStalls();
		testBranchSkip();
		testBranchLoop();
		testZeroRegister();

		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
logic/corePkg.sv
logic/pipeStage.sv
logic/fetchUnit.sv
logic/instrDecoder.sv
logic/regFile.sv
logic/pipeControl.sv
logic/execUnit.sv
logic/coreTop.sv
bench/coreTb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = coreTb
FILELIST = src.f
BUILDDIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)

run: compile
	./$(BUILDDIR)/V$(TOP)

clean:
	rm -rf $(BUILDDIR)
